/* all.f */
common/timer_pkg.sv
source/ahb_slave_port.sv
timer/timer_prescaler.sv
timer/timer_regs.sv
timer/ahb_timer_top.sv
tb/tb_ahb_timer.sv

/* Makefile */
# Verilator build, run, lint and clean for the AHB timer

VERILATOR  ?= verilator
TOP        ?= tb_ahb_timer
RTL_TOP    ?= ahb_timer_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_ahb_timer.sv */
// AHB timer testbench with table-driven register checks and prescaler and interrupt tests
`timescale 1ns/10ps

module tb_ahb_timer;

  import timer_pkg::*;

  localparam int WAIT_LIMIT   = 200;
  localparam int PRESCALE_VAL = 3;
  localparam int RATE_STEPS   = 5;

  // Table operation
  typedef enum logic {OP_WRITE, OP_READ} op_e;

  // One table row
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    hsize_e      size;
    logic [31:0] data;
    logic [31:0] expected;
  } stim_t;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  HSEL;
  logic [HADDR_SIZE-1:0] HADDR;
  logic [HDATA_SIZE-1:0] HWDATA;
  logic [HDATA_SIZE-1:0] HRDATA;
  logic                  HWRITE;
  hsize_e                HSIZE;
  htrans_e               HTRANS;
  logic                  HREADY;
  logic                  HREADYOUT;
  logic                  HRESP;
  logic                  tint;

  stim_t       stim_q[$];
  // Expected register words by word offset
  logic [31:0] model_mem [0:63];
  logic [31:0] lcg_state;
  logic [31:0] rd;
  logic [31:0] t_first;
  logic [31:0] t_second;

  ahb_timer_top i_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HRDATA    (HRDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .tint      (tint)
  );

  // 10 ns clock
  always #5 HCLK = ~HCLK;

  //////////////////////////////////////////////////
  // Checks and failure exit
  //////////////////////////////////////////////////
  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [HDATA_SIZE-1:0] got,
                            input logic [HDATA_SIZE-1:0] exp);
    if (got !== exp)
    begin
      $display("FAIL %t %s got %h expected %h", $realtime, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL %t %s got %b expected %b", $realtime, name, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////
  // Data phase ends when the slave is ready
  task automatic wait_ready();
    int n;
    n = 0;
    while (HREADYOUT !== 1'b1)
    begin
      if (n >= WAIT_LIMIT)
      begin
        $display("Timeout: HREADYOUT stayed low for %0d cycles", WAIT_LIMIT);
        stop_run();
      end
      else
      begin
        @(negedge HCLK);
        n++;
      end
    end
  endtask

  task automatic ahb_write(input logic [31:0] addr, input hsize_e size,
                           input logic [31:0] data);
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = 1'b1;
    HSIZE  = size;
    HTRANS = NONSEQ;
    @(negedge HCLK);
    // Data phase with the bus idle behind it
    HSEL   = 1'b0;
    HWRITE = 1'b0;
    HTRANS = IDLE;
    HWDATA = data;
    wait_ready();
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = 1'b0;
    HSIZE  = WORD;
    HTRANS = NONSEQ;
    @(negedge HCLK);
    HSEL   = 1'b0;
    HTRANS = IDLE;
    wait_ready();
    data = HRDATA;
  endtask

  // Poll tint at falling edges
  task automatic wait_tint(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (tint !== level)
    begin
      if (n >= max_cycles)
      begin
        $display("Timeout: tint did not reach %b within %0d cycles", level, max_cycles);
        stop_run();
      end
      else
      begin
        @(negedge HCLK);
        n++;
      end
    end
  endtask

  // Poll ipending over the bus while tint stays masked
  task automatic wait_pending(input logic [31:0] mask);
    logic [31:0] val;
    int n;
    n = 0;
    val = 32'h0;
    while ((val & mask) == 32'h0)
    begin
      if (n >= WAIT_LIMIT)
      begin
        $display("Timeout: pending bit %h never set", mask);
        stop_run();
      end
      else
      begin
        ahb_read(ADDR_IPENDING, val);
        check_bit("tint", tint, 1'b0);
        n++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model and stimulus table
  //////////////////////////////////////////////////
  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lanes covered by an aligned transfer
  function automatic bit lane_on(input logic [1:0] lo, input hsize_e size, input int lane);
    int nbytes;
    int first;
    case (size)
      BYTE:    nbytes = 1;
      HWORD:   nbytes = 2;
      default: nbytes = 4;
    endcase
    first = int'(lo) - (int'(lo) % nbytes);
    return (lane >= first) && (lane < first + nbytes);
  endfunction

  function automatic logic [31:0] cmp_addr(input int n, input bit hi);
    return ADDR_TIMECMP + 32'(8 * n) + (hi ? 32'h4 : 32'h0);
  endfunction

  function automatic void model_write(input logic [31:0] addr, input hsize_e size,
                                      input logic [31:0] data);
    logic [5:0] w;
    w = addr[7:2];
    // Reserved and ipending keep their value
    if ((w != ADDR_RESERVED[7:2]) && (w != ADDR_IPENDING[7:2]))
      for (int lane = 0; lane < BE_SIZE; lane++)
        if (lane_on(addr[1:0], size, lane))
          model_mem[w][lane*8 +: 8] = data[lane*8 +: 8];
  endfunction

  task automatic add_write(input logic [31:0] addr, input hsize_e size);
    stim_t s;
    s = '{op: OP_WRITE, addr: addr, size: size, data: rand_word(), expected: 32'h0};
    stim_q.push_back(s);
    model_write(addr, size, s.data);
  endtask

  task automatic add_read(input logic [31:0] addr);
    stim_t s;
    s = '{op: OP_READ, addr: addr, size: WORD, data: 32'h0, expected: model_mem[addr[7:2]]};
    stim_q.push_back(s);
  endtask

  // Time and all compare words
  task automatic add_read_back();
    for (int a = 4; a < 12; a++)
      add_read(32'(a * 4));
  endtask

  task automatic build_table();
    // Whole map after reset
    for (int a = 0; a < 12; a++)
      add_read(32'(a * 4));
    add_write(ADDR_TIME, WORD);
    add_write(ADDR_TIME_MSB, WORD);
    for (int n = 0; n < TIMERS; n++)
    begin
      add_write(cmp_addr(n, 1'b0), WORD);
      add_write(cmp_addr(n, 1'b1), WORD);
    end
    add_read_back();
    // Halfwords in both halves
    add_write(ADDR_TIME + 32'h2, HWORD);
    add_write(cmp_addr(0, 1'b0) + 32'h2, HWORD);
    add_write(cmp_addr(1, 1'b1), HWORD);
    add_write(cmp_addr(2, 1'b0) + 32'h2, HWORD);
    add_read_back();
    // Single bytes on every lane once
    add_write(ADDR_TIME_MSB + 32'h1, BYTE);
    add_write(ADDR_TIME + 32'h3, BYTE);
    add_write(cmp_addr(0, 1'b1) + 32'h3, BYTE);
    add_write(cmp_addr(1, 1'b0), BYTE);
    add_write(cmp_addr(2, 1'b1) + 32'h2, BYTE);
    add_read_back();
    add_write(ADDR_RESERVED, WORD);
    add_write(ADDR_IPENDING, WORD);
    add_read(ADDR_RESERVED);
    add_read(ADDR_IPENDING);
  endtask

  task automatic apply_table();
    logic [31:0] got;
    foreach (stim_q[i])
    begin
      if (stim_q[i].op == OP_WRITE)
        ahb_write(stim_q[i].addr, stim_q[i].size, stim_q[i].data);
      else
      begin
        ahb_read(stim_q[i].addr, got);
        check_data($sformatf("HRDATA[%h]", stim_q[i].addr), got, stim_q[i].expected);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    $timeformat(-9, 1, " ns", 10);
    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    HSEL      = 1'b0;
    HADDR     = 32'h0;
    HWDATA    = 32'h0;
    HWRITE    = 1'b0;
    HSIZE     = WORD;
    HTRANS    = IDLE;
    HREADY    = 1'b1;
    lcg_state = 32'd51;
    for (int i = 0; i < 64; i++)
      model_mem[i] = 32'h0;

    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    check_bit("tint", tint, 1'b0);
    check_bit("HREADYOUT", HREADYOUT, 1'b1);
    check_bit("HRESP", HRESP, HRESP_OKAY);

    // Reset values and byte lanes while the timer is stopped
    build_table();
    apply_table();

    // N time steps in N*(P+1) cycles between capture edges
    ahb_write(ADDR_PRESCALE, WORD, 32'(PRESCALE_VAL));
    ahb_read(ADDR_PRESCALE, rd);
    check_data("prescale", rd, 32'(PRESCALE_VAL));
    repeat (4) @(negedge HCLK);
    ahb_read(ADDR_TIME, t_first);
    repeat (RATE_STEPS * (PRESCALE_VAL + 1) - 2) @(negedge HCLK);
    ahb_read(ADDR_TIME, t_second);
    check_data("time delta", t_second - t_first, 32'(RATE_STEPS));

    // Interrupt on channel 1 with one count per cycle
    ahb_write(ADDR_PRESCALE, WORD, 32'h0);
    ahb_write(ADDR_TIME, WORD, 32'h0);
    ahb_write(ADDR_TIME_MSB, WORD, 32'h0);
    ahb_write(cmp_addr(1, 1'b0), WORD, 32'd40);
    ahb_write(cmp_addr(1, 1'b1), WORD, 32'h0);
    ahb_write(ADDR_IENABLE, WORD, 32'h2);
    ahb_read(ADDR_IPENDING, rd);
    check_data("ipending", rd, 32'h0);
    check_bit("tint", tint, 1'b0);
    wait_tint(1'b1, WAIT_LIMIT);
    ahb_read(ADDR_IPENDING, rd);
    check_data("ipending", rd, 32'h2);
    // Compare write rearms the channel
    ahb_write(cmp_addr(1, 1'b0), WORD, 32'hFFFF_0000);
    wait_tint(1'b0, 2);
    ahb_read(ADDR_IPENDING, rd);
    check_data("ipending", rd, 32'h0);

    // Channel 2 matches while masked
    ahb_write(ADDR_IENABLE, WORD, 32'hFFFF_FFFA);
    ahb_read(ADDR_IENABLE, rd);
    check_data("ienable", rd, 32'h2);
    ahb_read(ADDR_TIME, rd);
    ahb_write(cmp_addr(2, 1'b0), WORD, rd + 32'd40);
    ahb_write(cmp_addr(2, 1'b1), WORD, 32'h0);
    wait_pending(32'h4);
    ahb_write(ADDR_IPENDING, WORD, 32'hFFFF_FFFF);
    ahb_read(ADDR_IPENDING, rd);
    check_data("ipending", rd, 32'h4);
    repeat (3) @(negedge HCLK);
    check_bit("tint", tint, 1'b0);
    ahb_read(ADDR_RESERVED, rd);
    check_data("reserved", rd, 32'h0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule : tb_ahb_timer

/* timer/ahb_timer_top.sv */
// AHB3-Lite timer top, bus port, register bank and prescaler
`timescale 1ns/10ps

module ahb_timer_top (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             HSEL,
  input  logic [timer_pkg::HADDR_SIZE-1:0] HADDR,
  input  logic [timer_pkg::HDATA_SIZE-1:0] HWDATA,
  output logic [timer_pkg::HDATA_SIZE-1:0] HRDATA,
  input  logic                             HWRITE,
  input  timer_pkg::hsize_e                HSIZE,
  input  timer_pkg::htrans_e               HTRANS,
  input  logic                             HREADY,
  output logic                             HREADYOUT,
  output logic                             HRESP,
  output logic                             tint
);

  import timer_pkg::*;

  reg_access_t    wr_access;
  reg_access_t    rd_access;
  prescale_ctrl_t prescale_ctrl;
  logic           count_en;

  //////////////////////////////////////////////////
  // Zero wait state, never an error
  //////////////////////////////////////////////////
  assign HREADYOUT = 1'b1;
  assign HRESP     = HRESP_OKAY;

  // Bus side
  ahb_slave_port i_port (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .wr_access (wr_access),
    .rd_access (rd_access)
  );

  // Registers and compare
  timer_regs i_regs (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .wr_access     (wr_access),
    .rd_access     (rd_access),
    .HWDATA        (HWDATA),
    .count_en      (count_en),
    .HRDATA        (HRDATA),
    .prescale_ctrl (prescale_ctrl),
    .tint          (tint)
  );

  // Time base rate
  timer_prescaler i_prescaler (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .prescale_ctrl (prescale_ctrl),
    .count_en      (count_en)
  );

endmodule : ahb_timer_top

/* timer/timer_regs.sv */
// Timer register bank with time base, compare channels and interrupt
`timescale 1ns/10ps

module timer_regs (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  timer_pkg::reg_access_t           wr_access,
  input  timer_pkg::reg_access_t           rd_access,
  input  logic [timer_pkg::HDATA_SIZE-1:0] HWDATA,
  input  logic                             count_en,
  output logic [timer_pkg::HDATA_SIZE-1:0] HRDATA,
  output timer_pkg::prescale_ctrl_t        prescale_ctrl,
  output logic                             tint
);

  import timer_pkg::*;

  //////////////////////////////////////////////////
  // Register state
  //////////////////////////////////////////////////
  logic [31:0]             prescale_reg;
  logic                    enabled;
  logic                    reload;
  logic [TIMERS-1:0]       ienable;
  logic [TIMERS-1:0]       ipending;
  logic [63:0]             time_reg;
  logic [TIMERS-1:0][63:0] timecmp;

  // Zero-padded views of the control bits
  logic [HDATA_SIZE-1:0]   ienable_rd;
  logic [HDATA_SIZE-1:0]   ipending_rd;
  logic [HDATA_SIZE-1:0]   ienable_wr;
  logic [HDATA_SIZE-1:0]   rd_data;

  // Byte-lane merge of bus data into a word
  function automatic logic [HDATA_SIZE-1:0] merge(
    input logic [HDATA_SIZE-1:0] old_val,
    input logic [HDATA_SIZE-1:0] new_val,
    input logic [BE_SIZE-1:0]    be
  );
    logic [HDATA_SIZE-1:0] res;
    for (int n = 0; n < BE_SIZE; n++)
      res[n*8 +: 8] = be[n] ? new_val[n*8 +: 8] : old_val[n*8 +: 8];
    return res;
  endfunction

  assign ienable_rd  = {{(HDATA_SIZE-TIMERS){1'b0}}, ienable};
  assign ipending_rd = {{(HDATA_SIZE-TIMERS){1'b0}}, ipending};
  assign ienable_wr  = merge(ienable_rd, HWDATA, wr_access.be);

  //////////////////////////////////////////////////
  // Counting, compare and bus writes
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prescale_reg <= 32'h0;
      enabled      <= 1'b0;
      reload       <= 1'b0;
      ienable      <= '0;
      ipending     <= '0;
      time_reg     <= 64'h0;
      timecmp      <= '0;
    end
    else
    begin
      reload <= 1'b0;

      // Free-running time base
      if (count_en)
        time_reg <= time_reg + 64'h1;

      // Sticky pending on match
      for (int n = 0; n < TIMERS; n++)
        if (enabled && (timecmp[n] == time_reg))
          ipending[n] <= 1'b1;

      // Bus write wins over the above
      if (wr_access.write)
      begin
        case (wr_access.sel)
          REG_PRESCALE:
          begin
            prescale_reg <= merge(prescale_reg, HWDATA, wr_access.be);
            enabled      <= 1'b1;
            reload       <= 1'b1;
          end
          REG_IENABLE:    ienable         <= ienable_wr[TIMERS-1:0];
          REG_TIME_LO:    time_reg[31:0]  <= merge(time_reg[31:0], HWDATA, wr_access.be);
          REG_TIME_HI:    time_reg[63:32] <= merge(time_reg[63:32], HWDATA, wr_access.be);
          REG_TIMECMP_LO:
          begin
            timecmp[wr_access.idx][31:0] <=
              merge(timecmp[wr_access.idx][31:0], HWDATA, wr_access.be);
            // Rearm the channel
            ipending[wr_access.idx] <= 1'b0;
          end
          REG_TIMECMP_HI:
          begin
            timecmp[wr_access.idx][63:32] <=
              merge(timecmp[wr_access.idx][63:32], HWDATA, wr_access.be);
            ipending[wr_access.idx] <= 1'b0;
          end
          // Reserved and ipending are read only
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Read mux and interrupt
  //////////////////////////////////////////////////
  always_comb
  begin
    case (rd_access.sel)
      REG_PRESCALE:   rd_data = prescale_reg;
      REG_IPENDING:   rd_data = ipending_rd;
      REG_IENABLE:    rd_data = ienable_rd;
      REG_TIME_LO:    rd_data = time_reg[31:0];
      REG_TIME_HI:    rd_data = time_reg[63:32];
      REG_TIMECMP_LO: rd_data = timecmp[rd_access.idx][31:0];
      REG_TIMECMP_HI: rd_data = timecmp[rd_access.idx][63:32];
      default:        rd_data = '0;
    endcase
  end

  // Read data valid through the data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      HRDATA <= '0;
    else
      HRDATA <= rd_data;
  end

  // Masked pending, one cycle late
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      tint <= 1'b0;
    else
      tint <= |(ipending & ienable);
  end

  assign prescale_ctrl = '{value: prescale_reg, enabled: enabled, reload: reload};

endmodule : timer_regs

/* timer/timer_prescaler.sv */
// Timer prescaler, divides HCLK into a one-cycle count enable
`timescale 1ns/10ps

module timer_prescaler (
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  timer_pkg::prescale_ctrl_t prescale_ctrl,
  output logic                      count_en
);

  import timer_pkg::*;

  logic [31:0] prescale_cnt;
  logic        cnt_zero;

  assign cnt_zero = (prescale_cnt == 32'h0);

  //////////////////////////////////////////////////
  // Down counter
  //////////////////////////////////////////////////
  // Reload on new prescale value or at terminal count
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      prescale_cnt <= 32'h0;
    else if (prescale_ctrl.reload || cnt_zero)
      prescale_cnt <= prescale_ctrl.value;
    else
      prescale_cnt <= prescale_cnt - 32'h1;
  end

  // One pulse per value+1 cycles
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      count_en <= 1'b0;
    else if (!prescale_ctrl.enabled)
      count_en <= 1'b0;
    else
      count_en <= cnt_zero;
  end

endmodule : timer_prescaler

/* source/ahb_slave_port.sv */
// AHB slave port, captures the address phase and decodes register accesses
`timescale 1ns/10ps

module ahb_slave_port (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic                             HSEL,
  input  logic [timer_pkg::HADDR_SIZE-1:0] HADDR,
  input  logic                             HWRITE,
  input  timer_pkg::hsize_e                HSIZE,
  input  timer_pkg::htrans_e               HTRANS,
  input  logic                             HREADY,
  output timer_pkg::reg_access_t           wr_access,
  output timer_pkg::reg_access_t           rd_access
);

  import timer_pkg::*;

  //////////////////////////////////////////////////
  // Address phase decode
  //////////////////////////////////////////////////
  logic                   xfer_valid;
  logic [7:0]             addr_off;
  logic [7:0]             cmp_off;
  logic [7:0]             cmp_idx;
  reg_sel_e               dec_sel;
  logic [TIMER_IDX_W-1:0] dec_idx;
  logic [BE_SIZE-1:0]     dec_be;

  // Lane mask for size, shifted by low address bits
  function automatic logic [BE_SIZE-1:0] gen_be(input hsize_e size, input logic [1:0] lo);
    logic [BE_SIZE-1:0] be;
    case (size)
      BYTE:    be = 4'b0001 << lo;
      HWORD:   be = 4'b0011 << {lo[1], 1'b0};
      default: be = 4'b1111;
    endcase
    return be;
  endfunction

  // Only NONSEQ and SEQ carry data
  assign xfer_valid = HSEL && ((HTRANS == NONSEQ) || (HTRANS == SEQ));

  // Word offset inside the timer window
  assign addr_off = {HADDR[7:2], 2'b00};

  // Channel index, (offset - 0x18) / 8
  assign cmp_off = addr_off - ADDR_TIMECMP[7:0];
  assign cmp_idx = cmp_off >> 3;
  assign dec_idx = cmp_idx[TIMER_IDX_W-1:0];

  assign dec_be = gen_be(HSIZE, HADDR[1:0]);

  always_comb
  begin
    dec_sel = REG_RESERVED;
    if (addr_off >= ADDR_TIMECMP[7:0])
    begin
      // Channels past TIMERS fall back to reserved
      if (cmp_idx < TIMERS)
        dec_sel = HADDR[2] ? REG_TIMECMP_HI : REG_TIMECMP_LO;
    end
    else
    begin
      case (addr_off)
        ADDR_PRESCALE[7:0]: dec_sel = REG_PRESCALE;
        ADDR_IPENDING[7:0]: dec_sel = REG_IPENDING;
        ADDR_IENABLE[7:0]:  dec_sel = REG_IENABLE;
        ADDR_TIME[7:0]:     dec_sel = REG_TIME_LO;
        ADDR_TIME_MSB[7:0]: dec_sel = REG_TIME_HI;
        default:            dec_sel = REG_RESERVED;
      endcase
    end
  end

  // Read decode is used in the same cycle
  assign rd_access = '{sel: dec_sel, idx: dec_idx, be: dec_be, write: xfer_valid & HWRITE};

  //////////////////////////////////////////////////
  // Data phase pipeline for writes
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wr_access <= '{sel: REG_PRESCALE, idx: '0, be: '0, write: 1'b0};
    else if (HREADY)
    begin
      wr_access.sel   <= dec_sel;
      wr_access.idx   <= dec_idx;
      wr_access.be    <= dec_be;
      // Held for the whole data phase
      wr_access.write <= xfer_valid & HWRITE;
    end
  end

endmodule : ahb_slave_port

/* common/timer_pkg.sv */
// Timer package with bus widths, address map, enums and access structs
package timer_pkg;

  //////////////////////////////////////////////////
  // Bus and timer sizes
  //////////////////////////////////////////////////
  localparam int HADDR_SIZE  = 32;
  localparam int HDATA_SIZE  = 32;
  localparam int BE_SIZE     = 4;

  // Compare channels and index width
  localparam int TIMERS      = 3;
  localparam int TIMER_IDX_W = 2;

  // AHB response code
  localparam logic HRESP_OKAY = 1'b0;

  //////////////////////////////////////////////////
  // Address map, word offsets
  //////////////////////////////////////////////////
  localparam logic [HADDR_SIZE-1:0] ADDR_PRESCALE = 32'h00;
  localparam logic [HADDR_SIZE-1:0] ADDR_RESERVED = 32'h04;
  localparam logic [HADDR_SIZE-1:0] ADDR_IPENDING = 32'h08;
  localparam logic [HADDR_SIZE-1:0] ADDR_IENABLE  = 32'h0C;
  localparam logic [HADDR_SIZE-1:0] ADDR_TIME     = 32'h10;
  localparam logic [HADDR_SIZE-1:0] ADDR_TIME_MSB = 32'h14;
  // Channel n at 0x18 + 8n, high word at +4
  localparam logic [HADDR_SIZE-1:0] ADDR_TIMECMP  = 32'h18;

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // AHB transfer size, anything above WORD acts as WORD
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } hsize_e;

  // Register selector
  typedef enum logic [2:0] {
    REG_PRESCALE,
    REG_RESERVED,
    REG_IPENDING,
    REG_IENABLE,
    REG_TIME_LO,
    REG_TIME_HI,
    REG_TIMECMP_LO,
    REG_TIMECMP_HI
  } reg_sel_e;

  // One decoded bus access
  typedef struct packed {
    reg_sel_e               sel;
    logic [TIMER_IDX_W-1:0] idx;
    logic [BE_SIZE-1:0]     be;
    logic                   write;
  } reg_access_t;

  // Registers to prescaler
  typedef struct packed {
    logic [31:0] value;
    logic        enabled;
    logic        reload;
  } prescale_ctrl_t;

endpackage : timer_pkg
